// File: tb.f
verilog/axil_mem_pkg.sv
verilog/axil_fifo_client.sv
verilog/axil_mem_client.sv
verilog/uc_mem_target.sv
verilog/axil_mem_top.sv
verification/axil_mem_tb.sv

// File: verification/axil_mem_tb.sv
`timescale 1ns/1ps

module axil_mem_tb;

  import axil_mem_pkg::*;

  localparam int num_txn_lp = 92;
  localparam int stall_lp   = 6;

  logic                   clk_i;
  logic                   rst_n_i;
  logic [3:0]             lce_id_i;
  logic [2:0]             did_i;
  axil_aw_s               aw_i;
  logic                   awvalid_i;
  logic                   awready_o;
  axil_w_s                w_i;
  logic                   wvalid_i;
  logic                   wready_o;
  logic [1:0]             bresp_o;
  logic                   bvalid_o;
  logic                   bready_i;
  axil_ar_s               ar_i;
  logic                   arvalid_i;
  logic                   arready_o;
  logic [31:0]            rdata_o;
  logic [1:0]             rresp_o;
  logic                   rvalid_o;
  logic                   rready_i;

  logic [31:0]            ref_mem [mem_words_lp];
  logic [31:0]            lcg_state;
  int                     errors;
  int                     checks;

  axil_mem_top axil_mem_top_inst (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp)
    else
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Irregular masks write all four byte lanes
  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int nbytes;
    case (strb)
      4'h1:    nbytes = 1;
      4'h3:    nbytes = 2;
      default: nbytes = 4;
    endcase
    for (int i = 0; i < nbytes; i++)
      ref_mem[addr[9:2]][8*i +: 8] = data[8*i +: 8];
  endtask

  task automatic drive_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    aw_i.addr = addr;
    aw_i.prot = 3'b000;
    w_i.data  = data;
    w_i.strb  = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
  endtask

  task automatic wait_write_accept();
    @(negedge clk_i);
    while (!(awready_o && wready_o))
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  task automatic wait_read_accept();
    @(negedge clk_i);
    while (!arready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    arvalid_i = 1'b0;
  endtask

  // Counts cycles from the address handshake to the B or R valid
  task automatic wait_response(input bit is_wr, output int lat);
    lat = 0;
    do
    begin
      @(negedge clk_i);
      lat++;
    end
    while (is_wr ? !bvalid_o : !rvalid_o);
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int lat;
    drive_write(addr, data, strb);
    wait_write_accept();
    wait_response(1'b1, lat);
    check_value(lat, 3, "write latency");
    check_value(bresp_o, 2'b00, "bresp");
    @(posedge clk_i);
    #1;
    model_write(addr, data, strb);
  endtask

  task automatic axil_read(input logic [31:0] addr);
    int lat;
    ar_i.addr = addr;
    ar_i.prot = 3'b000;
    arvalid_i = 1'b1;
    wait_read_accept();
    wait_response(1'b0, lat);
    check_value(lat, 3, "read latency");
    check_value(rresp_o, 2'b00, "rresp");
    check_value(rdata_o, ref_mem[addr[9:2]], "rdata");
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_after_reset();
    repeat (4)
    begin
      @(negedge clk_i);
      check_value({awready_o, wready_o, arready_o, bvalid_o, rvalid_o}, 5'b0, "idle outputs");
    end
  endtask

  task automatic full_word_roundtrip();
    logic [31:0] addrs [32];
    for (int i = 0; i < 32; i++)
    begin
      addrs[i] = lcg_next() & ~32'h3;
      axil_write(addrs[i], lcg_next(), 4'hF);
    end
    for (int i = 0; i < 32; i++)
      axil_read(addrs[i]);
  endtask

  task automatic partial_mask_writes();
    logic [31:0] addr;
    repeat (2)
    begin
      addr = lcg_next() & ~32'h3;
      axil_write(addr, lcg_next(), 4'hF);
      axil_write(addr, lcg_next(), 4'h1);
      axil_read(addr);
      axil_write(addr, lcg_next(), 4'h3);
      axil_read(addr);
      axil_write(addr, lcg_next(), 4'h6);
      axil_read(addr);
    end
  endtask

  task automatic address_aliasing();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    repeat (2)
    begin
      addr_a = lcg_next() & 32'h0000_03FC;
      // Same index with nonzero bits above bit 9
      addr_b = addr_a | ((lcg_next() | 32'h400) & 32'hFFFF_FC00);
      axil_write(addr_a, lcg_next(), 4'hF);
      axil_read(addr_b);
      axil_write(addr_b, lcg_next(), 4'hF);
      axil_read(addr_a);
    end
  endtask

  task automatic response_backpressure();
    logic [31:0] addr;
    logic [31:0] addr2;
    logic [31:0] data;
    logic [31:0] data2;
    int          lat;
    addr  = lcg_next() & ~32'h3;
    addr2 = lcg_next() & ~32'h3;
    data  = lcg_next();
    data2 = lcg_next();
    bready_i = 1'b0;
    rready_i = 1'b0;
    drive_write(addr, data, 4'hF);
    wait_write_accept();
    wait_response(1'b1, lat);
    check_value(lat, 3, "stalled write latency");
    @(posedge clk_i);
    #1;
    ar_i.addr = addr;
    arvalid_i = 1'b1;
    // B held while a read waits outside
    repeat (stall_lp)
    begin
      @(negedge clk_i);
      check_value(bvalid_o, 1'b1, "bvalid held");
      check_value(arready_o, 1'b0, "arready during B stall");
    end
    @(posedge clk_i);
    #1;
    bready_i = 1'b1;
    model_write(addr, data, 4'hF);
    wait_read_accept();
    wait_response(1'b0, lat);
    check_value(lat, 3, "stalled read latency");
    @(posedge clk_i);
    #1;
    drive_write(addr2, data2, 4'hF);
    repeat (stall_lp)
    begin
      @(negedge clk_i);
      check_value(rvalid_o, 1'b1, "rvalid held");
      check_value(awready_o, 1'b0, "awready during R stall");
      check_value(rdata_o, ref_mem[addr[9:2]], "held rdata");
    end
    @(posedge clk_i);
    #1;
    rready_i = 1'b1;
    wait_write_accept();
    wait_response(1'b1, lat);
    check_value(lat, 3, "queued write latency");
    @(posedge clk_i);
    #1;
    model_write(addr2, data2, 4'hF);
    axil_read(addr2);
  endtask

  task automatic write_beats_read();
    logic [31:0] addr;
    logic [31:0] data;
    int          lat;
    addr = lcg_next() & ~32'h3;
    data = lcg_next();
    drive_write(addr, data, 4'hF);
    ar_i.addr = addr;
    ar_i.prot = 3'b000;
    arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!awready_o)
      @(negedge clk_i);
    check_value(arready_o, 1'b0, "arready with write offered");
    @(posedge clk_i);
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    wait_response(1'b1, lat);
    check_value(lat, 3, "write-first latency");
    @(posedge clk_i);
    #1;
    model_write(addr, data, 4'hF);
    wait_read_accept();
    wait_response(1'b0, lat);
    check_value(rdata_o, data, "read after simultaneous write");
    @(posedge clk_i);
    #1;
  endtask

  initial
  begin
    repeat (num_txn_lp * 50 + 2000) @(posedge clk_i);
    $display("ERROR: watchdog expired at %0t, the simulation hung", $time);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    lce_id_i  = 4'h5;
    did_i     = 3'h2;
    aw_i      = '0;
    awvalid_i = 1'b0;
    w_i       = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    ar_i      = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    lcg_state = 32'h1f35_d531;
    errors    = 0;
    checks    = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    idle_after_reset();
    full_word_roundtrip();
    partial_mask_writes();
    address_aliasing();
    response_backpressure();
    write_beats_read();
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog/axil_fifo_client.sv
`timescale 1ns/1ps

module axil_fifo_client
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,

    input  axil_mem_pkg::axil_aw_s                       aw_i,
    input  logic                                         awvalid_i,
    output logic                                         awready_o,

    input  axil_mem_pkg::axil_w_s                        w_i,
    input  logic                                         wvalid_i,
    output logic                                         wready_o,

    output logic [1:0]                                   bresp_o,
    output logic                                         bvalid_o,
    input  logic                                         bready_i,

    input  axil_mem_pkg::axil_ar_s                       ar_i,
    input  logic                                         arvalid_i,
    output logic                                         arready_o,

    output logic [axil_mem_pkg::axil_data_width_lp-1:0]  rdata_o,
    output logic [1:0]                                   rresp_o,
    output logic                                         rvalid_o,
    input  logic                                         rready_i,

    output axil_mem_pkg::axil_req_s                      req_o,
    output logic                                         req_v_o,
    input  logic                                         req_ready_and_i,

    input  logic [axil_mem_pkg::axil_data_width_lp-1:0]  resp_data_i,
    input  logic                                         resp_v_i,
    output logic                                         resp_ready_and_o
  );

  import axil_mem_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_request,
    e_wait,
    e_respond
  } state_e;

  state_e                        state_r;
  state_e                        state_n;
  axil_req_s                     req_r;
  logic [axil_data_width_lp-1:0] resp_data_r;
  logic                          wr_take;
  logic                          rd_take;
  logic                          resp_done;

  // Write needs AW and W together and beats a read offered alongside
  assign wr_take = (state_r == e_idle) && awvalid_i && wvalid_i;
  assign rd_take = (state_r == e_idle) && arvalid_i && !(awvalid_i && wvalid_i);

  assign awready_o = wr_take;
  assign wready_o  = wr_take;
  assign arready_o = rd_take;

  assign req_o            = req_r;
  assign req_v_o          = (state_r == e_request);
  assign resp_ready_and_o = (state_r == e_wait);

  // Direction of the held request picks B or R
  assign bvalid_o = (state_r == e_respond) && req_r.w;
  assign rvalid_o = (state_r == e_respond) && !req_r.w;
  assign rdata_o  = resp_data_r;
  assign bresp_o  = 2'b00;
  assign rresp_o  = 2'b00;

  assign resp_done = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:
        if (wr_take || rd_take)
          state_n = e_request;
      e_request:
        if (req_ready_and_i)
          state_n = e_wait;
      e_wait:
        if (resp_v_i)
          state_n = e_respond;
      e_respond:
        if (resp_done)
          state_n = e_idle;
      default:
        state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_take)
    begin
      req_r.addr  <= aw_i.addr;
      req_r.data  <= w_i.data;
      req_r.wmask <= w_i.strb;
      req_r.w     <= 1'b1;
    end
    else if (rd_take)
    begin
      req_r.addr  <= ar_i.addr;
      req_r.data  <= '0;
      // Reads always fetch the whole word
      req_r.wmask <= '1;
      req_r.w     <= 1'b0;
    end
    if (resp_ready_and_o && resp_v_i)
      resp_data_r <= resp_data_i;
  end

  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_v_o && !req_ready_and_i) |=> (req_v_o && $stable(req_o)));

  b_r_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bvalid_o && rvalid_o));

endmodule

// File: verilog/axil_mem_client.sv
`timescale 1ns/1ps

module axil_mem_client
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic [axil_mem_pkg::lce_id_width_lp-1:0]     lce_id_i,
    input  logic [axil_mem_pkg::did_width_lp-1:0]        did_i,

    input  axil_mem_pkg::axil_aw_s                       aw_i,
    input  logic                                         awvalid_i,
    output logic                                         awready_o,
    input  axil_mem_pkg::axil_w_s                        w_i,
    input  logic                                         wvalid_i,
    output logic                                         wready_o,
    output logic [1:0]                                   bresp_o,
    output logic                                         bvalid_o,
    input  logic                                         bready_i,
    input  axil_mem_pkg::axil_ar_s                       ar_i,
    input  logic                                         arvalid_i,
    output logic                                         arready_o,
    output logic [axil_mem_pkg::axil_data_width_lp-1:0]  rdata_o,
    output logic [1:0]                                   rresp_o,
    output logic                                         rvalid_o,
    input  logic                                         rready_i,

    output axil_mem_pkg::mem_header_s                    mem_fwd_header_o,
    output logic [axil_mem_pkg::axil_data_width_lp-1:0]  mem_fwd_data_o,
    output logic                                         mem_fwd_v_o,
    input  logic                                         mem_fwd_ready_and_i,

    input  axil_mem_pkg::mem_header_s                    mem_rev_header_i,
    input  logic [axil_mem_pkg::axil_data_width_lp-1:0]  mem_rev_data_i,
    input  logic                                         mem_rev_v_i,
    output logic                                         mem_rev_ready_and_o
  );

  import axil_mem_pkg::*;

  axil_req_s req;
  logic      outstanding_r;

  axil_fifo_client fifo_client_inst
    (
      .req_o            (req),
      .req_v_o          (mem_fwd_v_o),
      .req_ready_and_i  (mem_fwd_ready_and_i),
      .resp_data_i      (mem_rev_data_i),
      .resp_v_i         (mem_rev_v_i),
      .resp_ready_and_o (mem_rev_ready_and_o),
      .*
    );

  always_comb
  begin
    mem_fwd_data_o                   = req.data;
    mem_fwd_header_o.msg_type        = req.w ? e_mem_uc_wr : e_mem_uc_rd;
    mem_fwd_header_o.addr            = req.addr;
    mem_fwd_header_o.payload.lce_id  = lce_id_i;
    mem_fwd_header_o.payload.did     = did_i;
    // Low-lane masks shrink the size and irregular ones send a full word
    case (req.wmask)
      4'h1:    mem_fwd_header_o.size = e_msg_size_1;
      4'h3:    mem_fwd_header_o.size = e_msg_size_2;
      4'hF:    mem_fwd_header_o.size = e_msg_size_4;
      default: mem_fwd_header_o.size = e_msg_size_4;
    endcase
  end

  // Tracks a forward beat that has gone out and not yet been answered
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      outstanding_r <= 1'b0;
    else if (mem_fwd_v_o && mem_fwd_ready_and_i)
      outstanding_r <= 1'b1;
    else if (mem_rev_v_i && mem_rev_ready_and_o)
      outstanding_r <= 1'b0;
  end

  no_early_rev_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_fwd_v_o && !outstanding_r) |-> !mem_rev_v_i);

  rev_type_match_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_rev_v_i && mem_rev_ready_and_o) |-> (mem_rev_header_i.msg_type == req.w));

endmodule

// File: verilog/axil_mem_pkg.sv
package axil_mem_pkg;

  localparam int axil_data_width_lp = 32;
  localparam int axil_addr_width_lp = 32;
  localparam int axil_mask_width_lp = axil_data_width_lp / 8;
  localparam int lce_id_width_lp    = 4;
  localparam int did_width_lp       = 3;
  localparam int mem_words_lp       = 256;

  // Uncached operations only
  typedef enum logic {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } mem_msg_type_e;

  // Byte count code with 3 left unused
  typedef enum logic [1:0] {
    e_msg_size_1 = 2'b00,
    e_msg_size_2 = 2'b01,
    e_msg_size_4 = 2'b10
  } mem_msg_size_e;

  typedef struct packed {
    logic [lce_id_width_lp-1:0] lce_id;
    logic [did_width_lp-1:0]    did;
  } mem_payload_s;

  // Shared by the forward and reverse streams
  typedef struct packed {
    mem_msg_type_e                 msg_type;
    mem_msg_size_e                 size;
    logic [axil_addr_width_lp-1:0] addr;
    mem_payload_s                  payload;
  } mem_header_s;

  typedef struct packed {
    logic [axil_addr_width_lp-1:0] addr;
    logic [axil_data_width_lp-1:0] data;
    logic [axil_mask_width_lp-1:0] wmask;
    logic                          w;
  } axil_req_s;

  typedef struct packed {
    logic [axil_addr_width_lp-1:0] addr;
    logic [2:0]                    prot;
  } axil_aw_s;

  typedef struct packed {
    logic [axil_data_width_lp-1:0] data;
    logic [axil_mask_width_lp-1:0] strb;
  } axil_w_s;

  typedef struct packed {
    logic [axil_addr_width_lp-1:0] addr;
    logic [2:0]                    prot;
  } axil_ar_s;

endpackage

// File: verilog/axil_mem_top.sv
`timescale 1ns/1ps

module axil_mem_top
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic [axil_mem_pkg::lce_id_width_lp-1:0]     lce_id_i,
    input  logic [axil_mem_pkg::did_width_lp-1:0]        did_i,

    input  axil_mem_pkg::axil_aw_s                       aw_i,
    input  logic                                         awvalid_i,
    output logic                                         awready_o,
    input  axil_mem_pkg::axil_w_s                        w_i,
    input  logic                                         wvalid_i,
    output logic                                         wready_o,
    output logic [1:0]                                   bresp_o,
    output logic                                         bvalid_o,
    input  logic                                         bready_i,
    input  axil_mem_pkg::axil_ar_s                       ar_i,
    input  logic                                         arvalid_i,
    output logic                                         arready_o,
    output logic [axil_mem_pkg::axil_data_width_lp-1:0]  rdata_o,
    output logic [1:0]                                   rresp_o,
    output logic                                         rvalid_o,
    input  logic                                         rready_i
  );

  import axil_mem_pkg::*;

  mem_header_s                   mem_fwd_header;
  logic [axil_data_width_lp-1:0] mem_fwd_data;
  logic                          mem_fwd_v;
  logic                          mem_fwd_ready_and;
  mem_header_s                   mem_rev_header;
  logic [axil_data_width_lp-1:0] mem_rev_data;
  logic                          mem_rev_v;
  logic                          mem_rev_ready_and;

  axil_mem_client axil_mem_client_inst
    (
      .mem_fwd_header_o    (mem_fwd_header),
      .mem_fwd_data_o      (mem_fwd_data),
      .mem_fwd_v_o         (mem_fwd_v),
      .mem_fwd_ready_and_i (mem_fwd_ready_and),
      .mem_rev_header_i    (mem_rev_header),
      .mem_rev_data_i      (mem_rev_data),
      .mem_rev_v_i         (mem_rev_v),
      .mem_rev_ready_and_o (mem_rev_ready_and),
      .*
    );

  uc_mem_target uc_mem_target_inst
    (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .mem_fwd_header_i    (mem_fwd_header),
      .mem_fwd_data_i      (mem_fwd_data),
      .mem_fwd_v_i         (mem_fwd_v),
      .mem_fwd_ready_and_o (mem_fwd_ready_and),
      .mem_rev_header_o    (mem_rev_header),
      .mem_rev_data_o      (mem_rev_data),
      .mem_rev_v_o         (mem_rev_v),
      .mem_rev_ready_and_i (mem_rev_ready_and)
    );

endmodule

// File: verilog/uc_mem_target.sv
`timescale 1ns/1ps

module uc_mem_target
  (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,

    input  axil_mem_pkg::mem_header_s                    mem_fwd_header_i,
    input  logic [axil_mem_pkg::axil_data_width_lp-1:0]  mem_fwd_data_i,
    input  logic                                         mem_fwd_v_i,
    output logic                                         mem_fwd_ready_and_o,

    output axil_mem_pkg::mem_header_s                    mem_rev_header_o,
    output logic [axil_mem_pkg::axil_data_width_lp-1:0]  mem_rev_data_o,
    output logic                                         mem_rev_v_o,
    input  logic                                         mem_rev_ready_and_i
  );

  import axil_mem_pkg::*;

  localparam int idx_width_lp = $clog2(mem_words_lp);

  logic [axil_data_width_lp-1:0] mem_r [mem_words_lp];
  mem_header_s                   rev_header_r;
  logic [axil_data_width_lp-1:0] rev_data_r;
  logic                          rev_v_r;
  logic                          fwd_take;
  logic                          fwd_is_wr;
  logic [idx_width_lp-1:0]       word_idx;
  logic [axil_mask_width_lp-1:0] lane_en;

  // Input stalls while a response waits
  assign mem_fwd_ready_and_o = !rev_v_r;
  assign fwd_take            = mem_fwd_v_i && mem_fwd_ready_and_o;
  assign fwd_is_wr           = (mem_fwd_header_i.msg_type == e_mem_uc_wr);

  // Upper address bits are ignored and alias
  assign word_idx = mem_fwd_header_i.addr[idx_width_lp+1:2];

  assign mem_rev_header_o = rev_header_r;
  assign mem_rev_data_o   = rev_data_r;
  assign mem_rev_v_o      = rev_v_r;

  always_comb
  begin
    case (mem_fwd_header_i.size)
      e_msg_size_1: lane_en = 4'b0001;
      e_msg_size_2: lane_en = 4'b0011;
      default:      lane_en = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rev_v_r <= 1'b0;
    else if (fwd_take)
      rev_v_r <= 1'b1;
    else if (mem_rev_ready_and_i)
      rev_v_r <= 1'b0;
  end

  // Storage and response payload update in the acceptance cycle
  always_ff @(posedge clk_i)
  begin
    if (fwd_take)
    begin
      rev_header_r <= mem_fwd_header_i;
      if (fwd_is_wr)
      begin
        for (int i = 0; i < axil_mask_width_lp; i++)
        begin
          if (lane_en[i])
            mem_r[word_idx][8*i +: 8] <= mem_fwd_data_i[8*i +: 8];
        end
        rev_data_r <= '0;
      end
      else
      begin
        rev_data_r <= mem_r[word_idx];
      end
    end
  end

  fwd_size_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_fwd_v_i |-> (mem_fwd_header_i.size inside {e_msg_size_1, e_msg_size_2, e_msg_size_4}));

endmodule
